// File: all.f
+incdir+include
+incdir+test
design/idctPkg.sv
design/cosTable.sv
design/blockStore.sv
design/macUnit.sv
design/idctSequencer.sv
design/idctTop.sv
test/idctTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module idctTb -f all.f
output=$(./obj_dir/VidctTb)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
   exit 0
fi
exit 1

// File: test/idctRef.svh
`ifndef IDCT_REF_SVH
`define IDCT_REF_SVH

// round(128 * ck * cos((2i+1)k*pi/16)) with c0 = 1/sqrt(2)
function automatic int coefValue(input int i, input int k);
   real scale;
   real x;
   scale = (k == 0) ? 128.0 / $sqrt(2.0) : 128.0;
   x = scale * $cos((2 * i + 1) * k * 3.14159265358979 / 16.0);
   return (x < 0.0) ? -$rtoi(0.5 - x) : $rtoi(x + 0.5);
endfunction

// Temp[j][i] = sum over k of In[j][k] * C[i][k], wraps mod 2^32
function automatic void rowPassRef();
   int sum;
   for (int j = 0; j < `IDCT_DIM; j++)
   begin
      for (int i = 0; i < `IDCT_DIM; i++)
      begin
         sum = 0;
         for (int k = 0; k < `IDCT_DIM; k++)
            sum += inputBlock[j * `IDCT_DIM + k] * coefTable[i * `IDCT_DIM + k];
         tempRef[j * `IDCT_DIM + i] = sum;
      end
   end
endfunction

// Out[j][i] = sum over k of Temp[k][i] * C[j][k]
function automatic void colPassRef();
   int sum;
   for (int j = 0; j < `IDCT_DIM; j++)
   begin
      for (int i = 0; i < `IDCT_DIM; i++)
      begin
         sum = 0;
         for (int k = 0; k < `IDCT_DIM; k++)
            sum += tempRef[k * `IDCT_DIM + i] * coefTable[j * `IDCT_DIM + k];
         expectedBlock[j * `IDCT_DIM + i] = sum;
      end
   end
endfunction

function automatic int unsigned xorshift32(input int unsigned state);
   int unsigned x;
   x = state;
   x ^= x << 13;
   x ^= x >> 17;
   x ^= x << 5;
   return x;
endfunction

`endif

// File: test/idctTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "idct_config.svh"

module idctTb;

   localparam int timeoutCycles = 2000;

   logic clk = 1'b0;
   logic reset;
   logic start;
   idctPkg::wordT din;
   logic reading;
   logic done;
   idctPkg::wordT dout;

   int inputBlock[];
   int tempRef[];
   int expectedBlock[];
   int coefTable[];
   int unsigned rngState = 49;

   string testName = "none";
   int errorCount = 0;
   int testsRun = 0;
   int testsFailed = 0;
   bit timedOut = 1'b0;

   logic quietOpen = 1'b0;   // cycle right after reset release
   logic loadOpen = 1'b0;    // 64 capture cycles
   logic busy = 1'b0;        // compute, unload and idle gap
   logic unloadOpen = 1'b0;
   logic doneClosed = 1'b0;
   int expectedWord = 0;
   int wordIdx = 0;

   `include "idctRef.svh"

   idctTop uut (
      .clk(clk),
      .reset(reset),
      .start(start),
      .din(din),
      .reading(reading),
      .done(done),
      .dout(dout)
   );

   always #5 clk = ~clk;

   task automatic noteFailure(input string what);
      errorCount++;
      $display("%s: %s", testName, what);
   endtask

   task automatic logMismatch(input string what, input int expected, input int actual);
      errorCount++;
      $display("mismatch %s %s expected %0d actual %0d", testName, what, expected, actual);
   endtask

   // checked on the falling edge
   assert property (@(negedge clk) disable iff (reset) quietOpen |-> !reading && !done)
      else noteFailure("reading or done high after reset");
   assert property (@(negedge clk) disable iff (reset) quietOpen |-> dout == '0)
      else logMismatch("dout after reset", 0, dout);
   assert property (@(negedge clk) disable iff (reset) loadOpen |-> reading)
      else noteFailure("reading fell before 64 words were loaded");
   assert property (@(negedge clk) disable iff (reset) busy |-> !reading)
      else noteFailure("reading high outside the load window");
   assert property (@(negedge clk) disable iff (reset) unloadOpen |-> dout == expectedWord)
      else logMismatch($sformatf("word %0d", wordIdx), expectedWord, dout);
   assert property (@(negedge clk) disable iff (reset) unloadOpen |-> done)
      else noteFailure("done fell before the last output word");
   assert property (@(negedge clk) disable iff (reset) doneClosed |-> !done)
      else noteFailure("done still high after the last output word");

   task automatic processBlock(input bit injectStarts);
      int waitCount;
      busy = 1'b0;
      start = 1'b1;
      waitCount = 0;
      do
      begin
         @(posedge clk);
         #1;
         waitCount++;
      end
      while (!reading && waitCount < timeoutCycles);
      start = 1'b0;
      if (!reading)
      begin
         timedOut = 1'b1;
         noteFailure("reading never rose after the start pulse");
         return;
      end
      if (waitCount != 1)
      begin
         noteFailure("reading did not rise at the edge that saw start");
      end
      loadOpen = 1'b1;
      for (int n = 0; n < `IDCT_CELLS; n++)
      begin
         din = inputBlock[n];
         @(posedge clk);
         #1;
      end
      loadOpen = 1'b0;
      busy = 1'b1;
      din = '0;
      waitCount = 0;
      while (!done && waitCount < timeoutCycles)
      begin
         start = injectStarts && waitCount == 20;  // lands in the row pass
         @(posedge clk);
         #1;
         waitCount++;
      end
      start = 1'b0;
      if (!done)
      begin
         timedOut = 1'b1;
         noteFailure("done never rose after the block was loaded");
         return;
      end
      for (int n = 0; n < `IDCT_CELLS; n++)
      begin
         start = injectStarts && n == 10;  // mid unload
         @(posedge clk);
         #1;
         wordIdx = n;
         expectedWord = expectedBlock[n];
         unloadOpen = 1'b1;
      end
      start = 1'b0;
      @(posedge clk);
      #1;
      unloadOpen = 1'b0;
      doneClosed = 1'b1;
      @(posedge clk);
      #1;
      doneClosed = 1'b0;
      repeat (5) @(posedge clk);  // reading must stay low in the idle gap
      #1;
   endtask

   // kind 0 zeros, 1 impulse, 2 random, 3 random with stray starts
   task automatic runTest(input string name, input int kind);
      int errorsBefore;
      if (timedOut)
         return;
      testName = name;
      errorsBefore = errorCount;
      for (int n = 0; n < `IDCT_CELLS; n++)
      begin
         rngState = xorshift32(rngState);
         inputBlock[n] = (kind >= 2) ? int'(rngState % 511) - 255 : 0;
      end
      if (kind == 1)
      begin
         inputBlock[0] = 1;
         for (int n = 0; n < `IDCT_CELLS; n++)
            expectedBlock[n] = coefTable[(n / `IDCT_DIM) * `IDCT_DIM]
                             * coefTable[(n % `IDCT_DIM) * `IDCT_DIM];
      end
      else
      begin
         rowPassRef();
         colPassRef();
      end
      processBlock(kind == 3);
      testsRun++;
      if (errorCount == errorsBefore)
         $display("test %s: ok", name);
      else
      begin
         testsFailed++;
         $display("test %s: %0d failed checks", name, errorCount - errorsBefore);
      end
   endtask

   initial
   begin
      reset = 1'b1;
      start = 1'b0;
      din = '0;
      inputBlock = new[`IDCT_CELLS];
      tempRef = new[`IDCT_CELLS];
      expectedBlock = new[`IDCT_CELLS];
      coefTable = new[`IDCT_CELLS];
      for (int n = 0; n < `IDCT_CELLS; n++)
         coefTable[n] = coefValue(n / `IDCT_DIM, n % `IDCT_DIM);
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      testName = "reset";
      quietOpen = 1'b1;
      @(posedge clk);
      #1;
      quietOpen = 1'b0;
      testsRun++;
      if (errorCount == 0)
         $display("test reset: ok");
      else
      begin
         testsFailed++;
         $display("test reset: %0d failed checks", errorCount);
      end
      runTest("zeroBlock", 0);
      runTest("impulse", 1);
      runTest("random1", 2);
      runTest("random2", 2);
      runTest("random3", 2);
      runTest("ignoredStart", 3);
      $display("tests run %0d, tests failed %0d, failed checks %0d",
               testsRun, testsFailed, errorCount);
      if (errorCount == 0 && !timedOut)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: design/idctTop.sv
`timescale 1ns/1ps
`default_nettype none

module idctTop (
   input  logic          clk,
   input  logic          reset,
   input  logic          start,
   input  idctPkg::wordT din,
   output logic          reading,
   output logic          done,
   output idctPkg::wordT dout
);

   logic               loadEn;
   logic               readTemp;
   idctPkg::cellT      loadCell;
   idctPkg::cellT      operandCell;
   idctPkg::cellT      coefCell;
   idctPkg::cellT      unloadCell;
   idctPkg::macTagT    tag;
   idctPkg::macResultT result;
   idctPkg::wordT      operand;
   idctPkg::wordT      coef;

   idctSequencer sequencer (
      .clk(clk),
      .reset(reset),
      .start(start),
      .reading(reading),
      .done(done),
      .loadEn(loadEn),
      .loadCell(loadCell),
      .readTemp(readTemp),
      .operandCell(operandCell),
      .coefCell(coefCell),
      .tag(tag),
      .unloadCell(unloadCell)
   );

   blockStore store (
      .clk(clk),
      .reset(reset),
      .loadEn(loadEn),
      .loadCell(loadCell),
      .din(din),
      .readTemp(readTemp),
      .operandCell(operandCell),
      .operand(operand),
      .result(result),
      .unloadCell(unloadCell),
      .dout(dout)
   );

   cosTable table0 (
      .clk(clk),
      .coefCell(coefCell),
      .coef(coef)
   );

   macUnit mac (
      .clk(clk),
      .reset(reset),
      .tag(tag),
      .operand(operand),
      .coef(coef),
      .result(result)
   );

endmodule

`default_nettype wire

// File: design/idctSequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "idct_config.svh"

module idctSequencer (
   input  logic            clk,
   input  logic            reset,
   input  logic            start,
   output logic            reading,
   output logic            done,
   output logic            loadEn,
   output idctPkg::cellT   loadCell,
   output logic            readTemp,
   output idctPkg::cellT   operandCell,
   output idctPkg::cellT   coefCell,
   output idctPkg::macTagT tag,
   output idctPkg::cellT   unloadCell
);

   localparam int cntWidth = $clog2(`IDCT_CELLS * `IDCT_DIM);
   localparam logic [cntWidth-1:0] lastTerm = cntWidth'(`IDCT_CELLS * `IDCT_DIM - 1);
   localparam logic [cntWidth-1:0] lastCell = cntWidth'(`IDCT_CELLS - 1);
   localparam logic [cntWidth-1:0] lastDrain = cntWidth'(2);  // mac latency minus one

   idctPkg::seqStateT state;
   logic [cntWidth-1:0] termCnt;
   idctPkg::coordT rowIdx;    // output row j
   idctPkg::coordT colIdx;    // output column i
   idctPkg::coordT kIdx;      // summation index
   logic passActive;
   logic countEnd;

   assign {rowIdx, colIdx, kIdx} = termCnt;

   always_comb
   begin
      case (state)
         idctPkg::rowPass, idctPkg::colPass:
            countEnd = termCnt == lastTerm;
         idctPkg::rowDrain, idctPkg::colDrain:
            countEnd = termCnt == lastDrain;
         default:
            countEnd = termCnt == lastCell;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= idctPkg::idle;
         termCnt <= '0;
         done <= 1'b0;
      end
      else
      begin
         done <= (state == idctPkg::unload) || (state == idctPkg::colDrain && countEnd);
         if (countEnd || state == idctPkg::idle)
         begin
            termCnt <= '0;
         end
         else
         begin
            termCnt <= termCnt + cntWidth'(1);
         end
         case (state)
            idctPkg::idle:
               if (start)
                  state <= idctPkg::load;
            idctPkg::load:
               if (countEnd)
                  state <= idctPkg::rowPass;
            idctPkg::rowPass:
               if (countEnd)
                  state <= idctPkg::rowDrain;
            idctPkg::rowDrain:
               if (countEnd)
                  state <= idctPkg::colPass;  // temp block complete
            idctPkg::colPass:
               if (countEnd)
                  state <= idctPkg::colDrain;
            idctPkg::colDrain:
               if (countEnd)
                  state <= idctPkg::unload;
            idctPkg::unload:
               if (countEnd)
                  state <= idctPkg::idle;
            default:
               state <= idctPkg::idle;
         endcase
      end
   end

   assign reading = state == idctPkg::load;
   assign loadEn = reading;
   assign loadCell = '{row: colIdx, col: kIdx};  // count below 64 here
   assign unloadCell = '{row: colIdx, col: kIdx};

   assign passActive = state == idctPkg::rowPass || state == idctPkg::colPass;
   assign readTemp = state == idctPkg::colPass;

   // row pass In[j][k] * C[i][k], column pass Temp[k][i] * C[j][k]
   assign operandCell = readTemp ? '{row: kIdx, col: colIdx} : '{row: rowIdx, col: kIdx};
   assign coefCell = readTemp ? '{row: rowIdx, col: kIdx} : '{row: colIdx, col: kIdx};

   assign tag.valid = passActive;
   assign tag.first = kIdx == '0;
   assign tag.last = kIdx == idctPkg::coordT'(`IDCT_DIM - 1);
   assign tag.toOut = readTemp;
   assign tag.dest = '{row: rowIdx, col: colIdx};

   assert property (@(posedge clk) disable iff (reset)
      state inside {idctPkg::idle, idctPkg::load, idctPkg::rowPass, idctPkg::rowDrain,
                    idctPkg::colPass, idctPkg::colDrain, idctPkg::unload});

   assert property (@(posedge clk) disable iff (reset) !(done && reading));

endmodule

`default_nettype wire

// File: design/macUnit.sv
`timescale 1ns/1ps
`default_nettype none

module macUnit (
   input  logic               clk,
   input  logic               reset,
   input  idctPkg::macTagT    tag,
   input  idctPkg::wordT      operand,
   input  idctPkg::wordT      coef,
   output idctPkg::macResultT result
);

   idctPkg::macTagT tagD1;    // lines up with operand and coef
   idctPkg::macTagT tagD2;    // lines up with product
   idctPkg::wordT   product;
   idctPkg::wordT   acc;
   idctPkg::wordT   sum;

   assign sum = tagD2.first ? product : acc + product;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         tagD1 <= '0;
         tagD2 <= '0;
         result <= '0;
      end
      else
      begin
         tagD1 <= tag;
         tagD2 <= tagD1;
         result.valid <= tagD2.valid && tagD2.last;
         result.toOut <= tagD2.toOut;
         result.dest <= tagD2.dest;
         result.value <= sum;
      end
   end

   always_ff @(posedge clk)
   begin
      product <= operand * coef;  // low 32 bits only
      if (tagD2.valid)
      begin
         acc <= sum;
      end
   end

   // a closed sum is never continued by a stray term
   assert property (@(posedge clk) disable iff (reset)
      tag.valid && tag.last |=> !tag.valid || tag.first);

endmodule

`default_nettype wire

// File: design/blockStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "idct_config.svh"

module blockStore (
   input  logic               clk,
   input  logic               reset,
   input  logic               loadEn,
   input  idctPkg::cellT      loadCell,
   input  idctPkg::wordT      din,
   input  logic               readTemp,
   input  idctPkg::cellT      operandCell,
   output idctPkg::wordT      operand,
   input  idctPkg::macResultT result,
   input  idctPkg::cellT      unloadCell,
   output idctPkg::wordT      dout
);

   idctPkg::wordT inBlock   [`IDCT_DIM][`IDCT_DIM];
   idctPkg::wordT tempBlock [`IDCT_DIM][`IDCT_DIM];
   idctPkg::wordT outBlock  [`IDCT_DIM][`IDCT_DIM];

   always_ff @(posedge clk)
   begin
      if (loadEn)
      begin
         inBlock[loadCell.row][loadCell.col] <= din;
      end
      if (result.valid && !result.toOut)
      begin
         tempBlock[result.dest.row][result.dest.col] <= result.value;  // row pass
      end
      if (result.valid && result.toOut)
      begin
         outBlock[result.dest.row][result.dest.col] <= result.value;  // column pass
      end
   end

   always_ff @(posedge clk)
   begin
      if (readTemp)
      begin
         operand <= tempBlock[operandCell.row][operandCell.col];
      end
      else
      begin
         operand <= inBlock[operandCell.row][operandCell.col];
      end
   end

   // output port register, zero until the first unload
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         dout <= '0;
      end
      else
      begin
         dout <= outBlock[unloadCell.row][unloadCell.col];
      end
   end

   // loading and computing never overlap
   assert property (@(posedge clk) disable iff (reset) !(loadEn && result.valid));

endmodule

`default_nettype wire

// File: design/cosTable.sv
`timescale 1ns/1ps
`default_nettype none

`include "idct_config.svh"

module cosTable (
   input  logic          clk,
   input  idctPkg::cellT coefCell,
   output idctPkg::wordT coef
);

   // C[i][k] = round(128 * ck * cos((2i+1)k*pi/16)), row i, column k
   localparam logic signed [`IDCT_COEF_WIDTH-1:0] cosRom [`IDCT_CELLS] = '{
      8'sd91,  8'sd126,  8'sd118,  8'sd106,  8'sd91,  8'sd71,   8'sd49,   8'sd25,
      8'sd91,  8'sd106,  8'sd49,  -8'sd25,  -8'sd91, -8'sd126, -8'sd118, -8'sd71,
      8'sd91,  8'sd71,  -8'sd49,  -8'sd126, -8'sd91,  8'sd25,   8'sd118,  8'sd106,
      8'sd91,  8'sd25,  -8'sd118, -8'sd71,   8'sd91,  8'sd106, -8'sd49,  -8'sd126,
      8'sd91, -8'sd25,  -8'sd118,  8'sd71,   8'sd91, -8'sd106, -8'sd49,   8'sd126,
      8'sd91, -8'sd71,  -8'sd49,   8'sd126, -8'sd91, -8'sd25,   8'sd118, -8'sd106,
      8'sd91, -8'sd106,  8'sd49,   8'sd25,  -8'sd91,  8'sd126, -8'sd118,  8'sd71,
      8'sd91, -8'sd126,  8'sd118, -8'sd106,  8'sd91, -8'sd71,   8'sd49,  -8'sd25
   };

   always_ff @(posedge clk)
   begin
      coef <= idctPkg::wordT'(cosRom[{coefCell.row, coefCell.col}]);  // sign-extend
   end

   // the sequencer must hold a defined address in every state
   assert property (@(posedge clk) !$isunknown(coefCell));

endmodule

`default_nettype wire

// File: design/idctPkg.sv
`default_nettype none

`include "idct_config.svh"

package idctPkg;

   typedef logic signed [`IDCT_WORD_WIDTH-1:0] wordT;
   typedef logic [$clog2(`IDCT_DIM)-1:0] coordT;

   typedef struct packed {
      coordT row;
      coordT col;
   } cellT;

   typedef enum logic [2:0] {
      idle,
      load,
      rowPass,
      rowDrain,
      colPass,
      colDrain,
      unload
   } seqStateT;

   typedef struct packed {
      logic valid;
      logic first;  // restart the accumulator
      logic last;   // sum complete after this term
      logic toOut;  // column pass result
      cellT dest;
   } macTagT;

   typedef struct packed {
      logic valid;
      logic toOut;
      cellT dest;
      wordT value;
   } macResultT;

endpackage

`default_nettype wire

// File: include/idct_config.svh
`ifndef IDCT_CONFIG_SVH
`define IDCT_CONFIG_SVH

// data word, also the width of every partial and final sum
`define IDCT_WORD_WIDTH 32

// cosine constants are stored at this width and sign-extended on read
`define IDCT_COEF_WIDTH 8

`define IDCT_DIM 8     // block side
`define IDCT_CELLS 64  // IDCT_DIM squared

`endif
